/* bench/bankedRegFileTb.sv */
module bankedRegFileTb import regBankPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 4;
    localparam int DIRECTED_MAX  = 170;    // Upper bound of the directed sections
    localparam int RANDOM_CYCLES = 400;
    localparam int DRAIN_CYCLES  = 4;
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + DIRECTED_MAX + RANDOM_CYCLES + DRAIN_CYCLES + 100;

    // Expected outputs of one access
    typedef struct packed {
        regWord_t dataA;
        regWord_t dataB;
        logic     errWrite;
        logic     errReadA;
        logic     errReadB;
    } expResult_t;

    logic              clk;
    logic              rst;
    logic [MODE_W-1:0] mode;
    logic              wrEn;
    archReg_t          wrAddr;
    regWord_t          wrData;
    archReg_t          rdAddrA;
    archReg_t          rdAddrB;
    regWord_t          rdDataA;
    regWord_t          rdDataB;
    logic              errWrite;
    logic              errReadA;
    logic              errReadB;

    regWord_t   model [33];     // Physical registers as the testbench sees them
    expResult_t expQ [$];
    expResult_t pending;        // Result of the access on the inputs right now
    expResult_t current;
    int         errors = 0;
    int         checks = 0;
    integer     seed   = 32'h0491_8476;

    cpuMode_t legalModes [9] = '{modeUsr, modeFiq, modeIrq, modeSvc, modeMon,
                                 modeAbt, modeHyp, modeUnd, modeSys};
    cpuMode_t excModes [5] = '{modeIrq, modeSvc, modeMon, modeAbt, modeUnd};
    logic [MODE_W-1:0] badModes [4] = '{5'b00000, 5'b10100, 5'b11100, 5'b01111};

    bankedRegFile bankedRegFile_i (
        .clk      (clk),
        .rst      (rst),
        .mode     (mode),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .rdAddrA  (rdAddrA),
        .rdAddrB  (rdAddrB),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .errWrite (errWrite),
        .errReadA (errReadA),
        .errReadB (errReadB)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ########################################
    // Reference model
    // ########################################
    // Layout 0..14 common, 15..21 fiq R8..R14, 22..27 R13 bank, 28..32 R14 bank
    function automatic bit mapRef(
        input  logic [MODE_W-1:0] m,
        input  archReg_t          n,
        output int                idx
    );
        int slot;

        idx = 0;
        case (m)
            modeUsr, modeSys: slot = -1;
            modeFiq: slot = -2;
            modeIrq: slot = 0;
            modeSvc: slot = 1;
            modeMon: slot = 2;
            modeAbt: slot = 3;
            modeUnd: slot = 4;
            modeHyp: slot = 5;
            default: return 1'b0;           // Illegal mode
        endcase
        if (n == 4'd15) begin
            return 1'b0;
        end
        if (n <= 4'd7 || slot == -1 || (slot >= 0 && n <= 4'd12)) begin
            idx = int'(n);
            return 1'b1;
        end
        if (slot == -2) begin
            idx = 15 + int'(n) - 8;
            return 1'b1;
        end
        if (n == 4'd13) begin
            idx = 22 + slot;
            return 1'b1;
        end
        if (slot == 5) begin
            return 1'b0;                    // hyp has no R14
        end
        idx = 28 + slot;
        return 1'b1;
    endfunction

    // ########################################
    // Stimulus
    // ########################################
    task automatic applyAccess(
        input logic [MODE_W-1:0] m,
        input logic              we,
        input archReg_t          wa,
        input regWord_t          wd,
        input archReg_t          ra,
        input archReg_t          rb
    );
        int idxW;
        int idxA;
        int idxB;
        bit hitW;
        bit hitA;
        bit hitB;

        @(negedge clk);
        mode    = m;
        wrEn    = we;
        wrAddr  = wa;
        wrData  = wd;
        rdAddrA = ra;
        rdAddrB = rb;
        hitW = mapRef(m, wa, idxW);
        hitA = mapRef(m, ra, idxA);
        hitB = mapRef(m, rb, idxB);
        pending.dataA    = hitA ? model[idxA] : '0;
        pending.dataB    = hitB ? model[idxB] : '0;
        pending.errWrite = we && !hitW;
        pending.errReadA = !hitA;
        pending.errReadB = !hitB;
        // Reads above see the state before this write
        if (we && hitW) begin
            model[idxW] = wd;
        end
    endtask

    task automatic writeReg(input logic [MODE_W-1:0] m, input archReg_t n, input regWord_t d);
        applyAccess(m, 1'b1, n, d, 4'd0, 4'd0);
    endtask

    task automatic readRegs(input logic [MODE_W-1:0] m, input archReg_t a, input archReg_t b);
        applyAccess(m, 1'b0, 4'd0, '0, a, b);
    endtask

    // ########################################
    // Comparison
    // ########################################
    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            expQ.push_back(pending);    // DUT samples this access now
        end
    end

    // Outputs of an access are settled two falling edges after it was driven
    always @(negedge clk) begin
        if (expQ.size() >= 2) begin
            current = expQ.pop_front();
            checkVal("rdDataA", rdDataA, current.dataA);
            checkVal("rdDataB", rdDataB, current.dataB);
            checkVal("errWrite", errWrite, current.errWrite);
            checkVal("errReadA", errReadA, current.errReadA);
            checkVal("errReadB", errReadB, current.errReadB);
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Run timed out after %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    // ########################################
    // Test sequence
    // ########################################
    initial begin
        int                r;
        int                asserts;
        logic [MODE_W-1:0] rm;

        clk     = 1'b0;
        rst     = 1'b1;
        mode    = modeUsr;
        wrEn    = 1'b0;
        wrAddr  = '0;
        wrData  = '0;
        rdAddrA = '0;
        rdAddrB = '0;
        pending = '0;               // Idle usr read of R0
        for (int i = 0; i < 33; i++) begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Everything reads zero after reset
        for (int n = 0; n < 15; n++) begin
            readRegs(modeUsr, archReg_t'(n), archReg_t'(14 - n));
        end

        // Low registers are shared by all modes
        for (int n = 0; n < 8; n++) begin
            writeReg(modeSvc, archReg_t'(n), $random(seed));
        end
        for (int m = 0; m < 9; m++) begin
            for (int n = 0; n < 8; n++) begin
                readRegs(legalModes[m], archReg_t'(n), archReg_t'(7 - n));
            end
        end

        // fiq copies of R8 to R14 versus the usr ones
        for (int n = 8; n < 15; n++) begin
            writeReg(modeFiq, archReg_t'(n), $random(seed));
        end
        for (int n = 8; n < 15; n++) begin
            readRegs(modeUsr, archReg_t'(n), archReg_t'(n));
        end
        for (int n = 8; n < 15; n++) begin
            writeReg(modeUsr, archReg_t'(n), $random(seed));
        end
        for (int n = 8; n < 15; n++) begin
            readRegs(modeFiq, archReg_t'(n), archReg_t'(n));
        end

        // Banked SP and LR in every exception mode and in hyp
        for (int m = 0; m < 5; m++) begin
            writeReg(excModes[m], 4'd13, $random(seed));
            writeReg(excModes[m], 4'd14, $random(seed));
        end
        writeReg(modeUsr, 4'd13, $random(seed));
        writeReg(modeUsr, 4'd14, $random(seed));
        writeReg(modeHyp, 4'd13, $random(seed));
        writeReg(modeHyp, 4'd14, $random(seed));
        for (int m = 0; m < 9; m++) begin
            readRegs(legalModes[m], 4'd13, 4'd14);
        end

        // R15 and illegal mode codes
        for (int m = 0; m < 9; m++) begin
            applyAccess(legalModes[m], 1'b1, 4'd15, $random(seed), 4'd15, 4'd0);
        end
        for (int b = 0; b < 4; b++) begin
            applyAccess(badModes[b], 1'b1, 4'd3, $random(seed), 4'd3, 4'd15);
        end
        readRegs(modeUsr, 4'd3, 4'd15);
        readRegs(modeFiq, 4'd8, 4'd15);     // Slot next to the common R14
        readRegs(modeIrq, 4'd13, 4'd15);    // Slot next to the fiq R14

        // Random traffic where some reads hit the register written in the same cycle
        repeat (RANDOM_CYCLES) begin
            r = $random(seed);
            if (r[2:0] == 3'd0) begin
                rm = MODE_W'($random(seed));
            end else begin
                rm = legalModes[$unsigned($random(seed)) % 9];
            end
            applyAccess(rm, r[3], archReg_t'(r[11:8]), $random(seed),
                        (r[5:4] == 2'b00) ? archReg_t'(r[11:8]) : archReg_t'(r[15:12]),
                        archReg_t'(r[19:16]));
        end

        repeat (DRAIN_CYCLES) begin
            readRegs(modeUsr, 4'd0, 4'd1);
        end
        #(CLK_PERIOD / 4);          // Step off the falling edge before the report

        asserts = bankedRegFile_i.array_i.chk_i.failCount;
        $display("Checks: %0d, compare errors: %0d, assertion failures: %0d",
                 checks, errors, asserts);
        if (errors == 0 && asserts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* bench/bankedRegFile_chk.sv */
module bankedRegFileChk import regBankPkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     wrEn,
    input physReg_t wrIdx,
    input regWord_t rdDataA,
    input regWord_t rdDataB,
    input logic     errWrite,
    input logic     errReadA,
    input logic     errReadB
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;  // Read by the testbench at the end

    // ########################################
    // Storage stage properties
    // ########################################
    idxInRange: assert property (@(posedge clk) disable iff (rst)
        wrEn |-> (int'(wrIdx) < NUM_PHYS_REGS))
        else begin
            failCount++;
            $error("write index %0d outside the physical array", wrIdx);
        end

    zeroOnErrA: assert property (@(posedge clk) disable iff (rst)
        errReadA |-> (rdDataA == '0))
        else begin
            failCount++;
            $error("port A returned %h with its error flag set", rdDataA);
        end

    zeroOnErrB: assert property (@(posedge clk) disable iff (rst)
        errReadB |-> (rdDataB == '0))
        else begin
            failCount++;
            $error("port B returned %h with its error flag set", rdDataB);
        end

    // Flags must be driven once reset is gone
    flagsKnown: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({errWrite, errReadA, errReadB}))
        else begin
            failCount++;
            $error("error flags unknown after reset");
        end

endmodule

bind bankedRegArray bankedRegFileChk chk_i (
    .clk      (clk),
    .rst      (rst),
    .wrEn     (acc.wrEn),
    .wrIdx    (acc.wrIdx),
    .rdDataA  (rdDataA),
    .rdDataB  (rdDataB),
    .errWrite (errWrite),
    .errReadA (errReadA),
    .errReadB (errReadB)
);

/* logic/bankMapper.sv */
module bankMapper import regBankPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [MODE_W-1:0] mode,     // Raw M field, may be illegal
    input  logic              wrEn,
    input  archReg_t          wrAddr,
    input  regWord_t          wrData,
    input  archReg_t          rdAddrA,
    input  archReg_t          rdAddrB,
    regAccessIf.mapper        acc
);

    // ########################################
    // Mapping rule
    // ########################################
    // Returns 1 when num has a physical home in rawMode
    function automatic logic mapReg(
        input  logic [MODE_W-1:0] rawMode,
        input  archReg_t          num,
        output physReg_t          idx
    );
        logic hit;
        logic banked;   // Mode owns its own R13 and maybe R14
        logic hasLr;
        int   slot;

        hit    = 1'b1;
        banked = 1'b0;
        hasLr  = 1'b1;
        slot   = SLOT_IRQ;
        idx    = physReg_t'(COMMON_BASE + int'(num));

        case (rawMode)
            modeUsr, modeSys: ;     // Whole common bank
            modeFiq: begin
                if (int'(num) > LAST_FIQ_SHARED) begin
                    idx = physReg_t'(FIQ_BASE + int'(num) - LAST_FIQ_SHARED - 1);
                end
            end
            modeIrq: begin
                banked = 1'b1;
                slot   = SLOT_IRQ;
            end
            modeSvc: begin
                banked = 1'b1;
                slot   = SLOT_SVC;
            end
            modeMon: begin
                banked = 1'b1;
                slot   = SLOT_MON;
            end
            modeAbt: begin
                banked = 1'b1;
                slot   = SLOT_ABT;
            end
            modeUnd: begin
                banked = 1'b1;
                slot   = SLOT_UND;
            end
            modeHyp: begin
                banked = 1'b1;
                slot   = SLOT_HYP;
                hasLr  = 1'b0;      // No R14 in hyp
            end
            default: hit = 1'b0;    // Illegal mode code
        endcase

        if (banked && int'(num) > LAST_SHARED) begin
            if (num == ARCH_SP) begin
                idx = physReg_t'(R13_BANK_BASE + slot);
            end else if (num == ARCH_LR && hasLr) begin
                idx = physReg_t'(R14_BANK_BASE + slot);
            end else begin
                hit = 1'b0;
            end
        end

        // PC is outside this block in every mode
        if (num == ARCH_PC) begin
            hit = 1'b0;
        end

        return hit;
    endfunction

    // ########################################
    // Decode
    // ########################################
    logic     wrHit;
    logic     rdHitA;
    logic     rdHitB;
    physReg_t wrIdxNext;
    physReg_t rdIdxNextA;
    physReg_t rdIdxNextB;

    always_comb begin
        wrHit  = mapReg(mode, wrAddr, wrIdxNext);
        rdHitA = mapReg(mode, rdAddrA, rdIdxNextA);
        rdHitB = mapReg(mode, rdAddrB, rdIdxNextB);
    end

    // ########################################
    // Stage register
    // ########################################
    always_ff @(posedge clk) begin
        if (rst) begin
            acc.wrEn     <= 1'b0;
            acc.wrIdx    <= '0;
            acc.rdIdxA   <= '0;
            acc.rdIdxB   <= '0;
            acc.errWrite <= 1'b0;
            acc.errReadA <= 1'b0;
            acc.errReadB <= 1'b0;
        end else begin
            acc.wrEn     <= wrEn & wrHit;       // Unmapped write is dropped here
            acc.wrIdx    <= wrIdxNext;
            acc.rdIdxA   <= rdIdxNextA;
            acc.rdIdxB   <= rdIdxNextB;
            acc.errWrite <= wrEn & ~wrHit;      // Only a real write can fail
            acc.errReadA <= ~rdHitA;
            acc.errReadB <= ~rdHitB;
        end
    end

    // Write data rides along with the index
    always_ff @(posedge clk) begin
        acc.wrData <= wrData;
    end

endmodule

/* logic/bankedRegArray.sv */
module bankedRegArray import regBankPkg::*; (
    input  logic       clk,
    input  logic       rst,
    regAccessIf.array  acc,
    output regWord_t   rdDataA,
    output regWord_t   rdDataB,
    output logic       errWrite,
    output logic       errReadA,
    output logic       errReadB
);

    // ########################################
    // Storage
    // ########################################
    // Common bank, fiq bank, then the R13 and R14 banks
    regWord_t regs [NUM_PHYS_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (acc.wrEn) begin
            regs[acc.wrIdx] <= acc.wrData;  // Index already checked upstream
        end
    end

    // ########################################
    // Read ports
    // ########################################
    // A failed decode reads as zero
    function automatic regWord_t readSlot(
        input physReg_t idx,
        input logic     err
    );
        regWord_t value;

        value = '0;
        if (!err) begin
            value = regs[idx];
        end
        return value;
    endfunction

    // Nonblocking write above, so a same-cycle read gets the old value
    always_ff @(posedge clk) begin
        if (rst) begin
            rdDataA <= '0;
            rdDataB <= '0;
        end else begin
            rdDataA <= readSlot(acc.rdIdxA, acc.errReadA);
            rdDataB <= readSlot(acc.rdIdxB, acc.errReadB);
        end
    end

    // ########################################
    // Error alignment
    // ########################################
    // One extra stage so the flags leave together with the data
    always_ff @(posedge clk) begin
        if (rst) begin
            errWrite <= 1'b0;
            errReadA <= 1'b0;
            errReadB <= 1'b0;
        end else begin
            errWrite <= acc.errWrite;
            errReadA <= acc.errReadA;
            errReadB <= acc.errReadB;
        end
    end

endmodule

/* logic/bankedRegFile.sv */
module bankedRegFile import regBankPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [MODE_W-1:0] mode,
    input  logic              wrEn,
    input  archReg_t          wrAddr,
    input  regWord_t          wrData,
    input  archReg_t          rdAddrA,
    input  archReg_t          rdAddrB,
    output regWord_t          rdDataA,
    output regWord_t          rdDataB,
    output logic              errWrite,
    output logic              errReadA,
    output logic              errReadB
);

    // Decoded access between the two pipeline stages
    regAccessIf acc ();

    // ########################################
    // Stage 1, mode and number decode
    // ########################################
    bankMapper mapper_i (
        .clk     (clk),
        .rst     (rst),
        .mode    (mode),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .acc     (acc.mapper)
    );

    // ########################################
    // Stage 2, storage and read registers
    // ########################################
    bankedRegArray array_i (
        .clk      (clk),
        .rst      (rst),
        .acc      (acc.array),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .errWrite (errWrite),
        .errReadA (errReadA),
        .errReadB (errReadB)
    );

endmodule

/* logic/regAccessIf.sv */
interface regAccessIf import regBankPkg::*; ();

    // Write side, already legal and resolved to a physical slot
    logic     wrEn;
    physReg_t wrIdx;
    regWord_t wrData;

    // Two read ports
    physReg_t rdIdxA;
    physReg_t rdIdxB;

    // Decode errors, raised for one access only
    logic     errWrite;
    logic     errReadA;
    logic     errReadB;

    modport mapper (
        output wrEn,
        output wrIdx,
        output wrData,
        output rdIdxA,
        output rdIdxB,
        output errWrite,
        output errReadA,
        output errReadB
    );

    modport array (
        input  wrEn,
        input  wrIdx,
        input  wrData,
        input  rdIdxA,
        input  rdIdxB,
        input  errWrite,
        input  errReadA,
        input  errReadB
    );

endinterface

/* logic/regBankPkg.sv */
package regBankPkg;

    // ########################################
    // Widths
    // ########################################
    localparam int WORD_W = 32;
    localparam int ARCH_W = 4;
    localparam int PHYS_W = 6;
    localparam int MODE_W = 5;

    typedef logic [WORD_W-1:0] regWord_t;   // One register value
    typedef logic [ARCH_W-1:0] archReg_t;   // R0 to R15 as seen by software
    typedef logic [PHYS_W-1:0] physReg_t;   // Slot in the physical array

    // ########################################
    // Processor modes
    // ########################################
    // Encodings follow the CPSR M field, every other code is illegal
    typedef enum logic [MODE_W-1:0] {
        modeUsr = 5'b10000,
        modeFiq = 5'b10001,
        modeIrq = 5'b10010,
        modeSvc = 5'b10011,
        modeMon = 5'b10110,
        modeAbt = 5'b10111,
        modeHyp = 5'b11010,
        modeUnd = 5'b11011,
        modeSys = 5'b11111
    } cpuMode_t;

    // ########################################
    // Physical layout
    // ########################################
    localparam int NUM_PHYS_REGS = 33;

    // Shared R0 to R14, used as is by usr and sys
    localparam int COMMON_BASE = 0;

    // Private R8 to R14 of fiq
    localparam int FIQ_BASE = 15;

    // One R13 per exception mode, hyp included
    localparam int R13_BANK_BASE = 22;

    // One R14 per exception mode, hyp has none
    localparam int R14_BANK_BASE = 28;

    // Order of the per-mode slots inside the R13 and R14 banks
    localparam int SLOT_IRQ = 0;
    localparam int SLOT_SVC = 1;
    localparam int SLOT_MON = 2;
    localparam int SLOT_ABT = 3;
    localparam int SLOT_UND = 4;
    localparam int SLOT_HYP = 5;    // R13 bank only

    // Highest number still taken from the common bank
    localparam int LAST_FIQ_SHARED = 7;
    localparam int LAST_SHARED     = 12;

    // Architectural numbers with a special role
    localparam int ARCH_SP = 13;
    localparam int ARCH_LR = 14;
    localparam int ARCH_PC = 15;    // Not held here, never mapped

endpackage

/* verilog.f */
logic/regBankPkg.sv
logic/regAccessIf.sv
logic/bankMapper.sv
logic/bankedRegArray.sv
logic/bankedRegFile.sv
bench/bankedRegFile_chk.sv
bench/bankedRegFileTb.sv
